// ==== hw/audio_params.svh ====
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Audio RAM geometry
`define AUDIO_CHANNELS 8
`define AUDIO_FRAMES 256

// I2S timing, 32 MHz / 15 gives roughly a 2.13 MHz bit clock
`define I2S_DIVIDER 15
`define I2S_SAMPLE_DELAY 5
`define I2S_SLOTS 64

// Host bus regions, matched against adr[31:24]
`define ADDR_STATUS 8'h62
`define ADDR_INPUT 8'h64

`endif

// ==== hw/audio_pkg.sv ====
`include "audio_params.svh"

package audio_pkg;

    // One audio sample
    typedef logic [15:0] sample_t;

    // Channel and frame indices
    typedef logic [$clog2(`AUDIO_CHANNELS)-1:0] chan_t;
    typedef logic [$clog2(`AUDIO_FRAMES)-1:0] frame_t;

    // Channel in the upper bits, frame in the lower bits
    typedef logic [$clog2(`AUDIO_CHANNELS * `AUDIO_FRAMES)-1:0] audio_addr_t;

    // Bit slot within an I2S frame
    typedef logic [$clog2(`I2S_SLOTS)-1:0] slot_t;

    // Host bus data word
    typedef logic [31:0] bus_word_t;

endpackage

// ==== hw/i2s_clock.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module i2s_clock (
    input  logic               ck,
    input  logic               rst_n,
    output logic               bit_en,
    output logic               sck,
    output logic               ws,
    output audio_pkg::slot_t   slot,
    output logic               frame_start
);

    import audio_pkg::*;

    localparam int DIV_W = $clog2(`I2S_DIVIDER);
    // sck high for the first half of each slot
    localparam int SCK_HIGH = `I2S_DIVIDER / 2;

    logic [DIV_W-1:0] div;
    logic [DIV_W-1:0] div_next;
    logic             div_wrap;

    assign div_wrap = (div == DIV_W'(`I2S_DIVIDER - 1));
    assign div_next = div_wrap ? '0 : div + 1'b1;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            div         <= '0;
            slot        <= '0;
            bit_en      <= 1'b0;
            sck         <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            div    <= div_next;
            bit_en <= div_wrap;
            sck    <= (div_next < DIV_W'(SCK_HIGH));
            // Slot and bit_en change together, at the start of the new slot
            if (div_wrap) begin
                slot <= slot + 1'b1;
            end
            frame_start <= div_wrap && (slot == slot_t'(`I2S_SLOTS - 1));
        end
    end

    // Word select follows the upper half of the frame
    assign ws = slot[$bits(slot_t)-1];

endmodule

// ==== hw/i2s_rx.sv ====
`timescale 1ns/1ps

module i2s_rx (
    input  logic                ck,
    input  logic                rst_n,
    input  logic                sample_en,
    input  audio_pkg::slot_t    slot,
    input  logic                sd,
    output audio_pkg::sample_t  left,
    output audio_pkg::sample_t  right
);

    import audio_pkg::*;

    localparam int POS_W = $bits(slot_t) - 1;
    localparam int WORD = $bits(sample_t);

    logic [POS_W-1:0] pos;
    logic             is_right;
    logic             in_word;
    logic             last_bit;
    sample_t          shift;
    sample_t          shift_next;

    // Position within the current half frame
    assign pos      = slot[POS_W-1:0];
    assign is_right = slot[POS_W];

    // Word occupies slots 1..16 of each half, MSB first
    assign in_word  = (pos >= POS_W'(1)) && (pos <= POS_W'(WORD));
    assign last_bit = (pos == POS_W'(WORD));

    assign shift_next = {shift[WORD-2:0], sd};

    always_ff @(posedge ck) begin
        if (sample_en && in_word) begin
            shift <= shift_next;
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else if (sample_en && last_bit) begin
            if (is_right) begin
                right <= shift_next;
            end else begin
                left <= shift_next;
            end
        end
    end

endmodule

// ==== hw/audio_capture.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_capture (
    input  logic                  ck,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  audio_pkg::sample_t    mic [`AUDIO_CHANNELS],
    input  logic                  allow_audio_writes,
    input  logic                  host_we,
    input  audio_pkg::audio_addr_t host_waddr,
    input  audio_pkg::sample_t    host_wdata,
    output audio_pkg::frame_t     frame,
    output logic                  ram_we,
    output audio_pkg::audio_addr_t ram_waddr,
    output audio_pkg::sample_t    ram_wdata
);

    import audio_pkg::*;

    chan_t       chan;
    logic        writing;
    audio_addr_t cap_addr;
    sample_t     cap_data;

    // Frame counter and the eight-write burst after each frame_start
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            frame   <= '0;
            chan    <= '0;
            writing <= 1'b0;
        end else if (allow_audio_writes) begin
            // Host owns the RAM, counter frozen
            writing <= 1'b0;
        end else if (frame_start) begin
            frame   <= frame - 1'b1;
            chan    <= '0;
            writing <= 1'b1;
        end else if (writing) begin
            chan <= chan + 1'b1;
            if (chan == chan_t'(`AUDIO_CHANNELS - 1)) begin
                writing <= 1'b0;
            end
        end
    end

    assign cap_addr = {chan, frame};
    assign cap_data = mic[chan];

    // Write port belongs to the host while the mode bit is set
    always_comb begin
        if (allow_audio_writes) begin
            ram_we    = host_we;
            ram_waddr = host_waddr;
            ram_wdata = host_wdata;
        end else begin
            ram_we    = writing;
            ram_waddr = cap_addr;
            ram_wdata = cap_data;
        end
    end

endmodule

// ==== hw/audio_ram.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_ram (
    input  logic                   ck,
    input  logic                   we,
    input  audio_pkg::audio_addr_t waddr,
    input  audio_pkg::sample_t     wdata,
    input  audio_pkg::audio_addr_t raddr,
    output audio_pkg::sample_t     rdata
);

    import audio_pkg::*;

    localparam int DEPTH = `AUDIO_CHANNELS * `AUDIO_FRAMES;

    sample_t mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Read data one cycle after the address
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/host_regs.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module host_regs (
    input  logic                   ck,
    input  logic                   rst_n,
    input  logic                   cyc,
    input  logic                   we,
    input  audio_pkg::bus_word_t   adr,
    input  audio_pkg::bus_word_t   dat,
    output logic                   ack,
    output audio_pkg::bus_word_t   rdt,
    input  audio_pkg::frame_t      frame,
    output logic                   allow_audio_writes,
    output logic                   host_we,
    output audio_pkg::audio_addr_t host_waddr,
    output audio_pkg::sample_t     host_wdata,
    output audio_pkg::audio_addr_t ram_raddr,
    input  audio_pkg::sample_t     ram_rdata
);

    import audio_pkg::*;

    localparam int NREGIONS = 2;
    localparam int R_STATUS = 0;
    localparam int R_INPUT = 1;
    localparam logic [7:0] REGION [NREGIONS] = '{`ADDR_STATUS, `ADDR_INPUT};

    logic                cyc_d;
    logic                start;
    logic [NREGIONS-1:0] hit;
    logic [NREGIONS-1:0] region_ack;
    logic [21:0]         offset;
    audio_addr_t         word_addr;
    bus_word_t           status_word;

    // First cycle of a bus cycle
    assign start = cyc && !cyc_d;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            cyc_d <= 1'b0;
        end else begin
            cyc_d <= cyc;
        end
    end

    // One registered one-shot ack per region
    for (genvar r = 0; r < NREGIONS; r++) begin : g_region
        assign hit[r] = (adr[31:24] == REGION[r]);

        always_ff @(posedge ck) begin
            if (!rst_n) begin
                region_ack[r] <= 1'b0;
            end else begin
                region_ack[r] <= start && hit[r];
            end
        end
    end

    assign ack = |region_ack;

    // Word offset within a region
    assign offset    = adr[23:2];
    assign word_addr = adr[$bits(audio_addr_t)+1:2];

    // Control register, bit 0 only
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            allow_audio_writes <= 1'b0;
        end else if (start && hit[R_STATUS] && we && (offset == '0)) begin
            allow_audio_writes <= dat[0];
        end
    end

    always_comb begin
        case (offset)
            22'd0:   status_word = {31'h0, allow_audio_writes};
            22'd1:   status_word = {{($bits(bus_word_t) - $bits(frame_t)){1'b0}}, frame};
            default: status_word = '0;
        endcase
    end

    // Audio RAM access, writes are gated by the mode in audio_capture
    assign host_we    = start && hit[R_INPUT] && we;
    assign host_waddr = word_addr;
    assign host_wdata = dat[$bits(sample_t)-1:0];
    assign ram_raddr  = word_addr;

    // Fields are still held during ack, so we selects the read data
    always_comb begin
        rdt = '0;
        if (!we) begin
            if (region_ack[R_STATUS]) begin
                rdt = status_word;
            end else if (region_ack[R_INPUT]) begin
                rdt = {{($bits(bus_word_t) - $bits(sample_t)){1'b0}}, ram_rdata};
            end
        end
    end

endmodule

// ==== hw/audio_engine.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_engine (
    input  logic                 ck,
    input  logic                 rst_n,

    // Host bus
    input  logic                 cyc,
    input  logic                 we,
    input  audio_pkg::bus_word_t adr,
    input  audio_pkg::bus_word_t dat,
    output logic                 ack,
    output audio_pkg::bus_word_t rdt,

    // I2S pins
    output logic                 sck,
    output logic                 ws,
    input  logic                 sd_in0,
    input  logic                 sd_in1,
    input  logic                 sd_in2,
    input  logic                 sd_in3,

    output logic                 frame_start
);

    import audio_pkg::*;

    localparam int LINES = `AUDIO_CHANNELS / 2;

    logic                         bit_en;
    logic                         sample_en;
    logic [`I2S_SAMPLE_DELAY-1:0] bit_en_d;
    slot_t                        slot;
    logic [LINES-1:0]             sd;
    sample_t                      mic [`AUDIO_CHANNELS];

    logic        allow_audio_writes;
    frame_t      frame;
    logic        host_we;
    audio_addr_t host_waddr;
    sample_t     host_wdata;
    logic        ram_we;
    audio_addr_t ram_waddr;
    sample_t     ram_wdata;
    audio_addr_t ram_raddr;
    sample_t     ram_rdata;

    i2s_clock u_clock (
        .ck          (ck),
        .rst_n       (rst_n),
        .bit_en      (bit_en),
        .sck         (sck),
        .ws          (ws),
        .slot        (slot),
        .frame_start (frame_start)
    );

    // Move the sample point into the stable half of the bit
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            bit_en_d <= '0;
        end else begin
            bit_en_d <= {bit_en_d[`I2S_SAMPLE_DELAY-2:0], bit_en};
        end
    end

    assign sample_en = bit_en_d[`I2S_SAMPLE_DELAY-1];

    assign sd = {sd_in3, sd_in2, sd_in1, sd_in0};

    // Line n feeds channels 2n and 2n+1
    for (genvar n = 0; n < LINES; n++) begin : g_rx
        i2s_rx u_rx (
            .ck        (ck),
            .rst_n     (rst_n),
            .sample_en (sample_en),
            .slot      (slot),
            .sd        (sd[n]),
            .left      (mic[2*n]),
            .right     (mic[2*n+1])
        );
    end

    audio_capture u_capture (
        .ck                 (ck),
        .rst_n              (rst_n),
        .frame_start        (frame_start),
        .mic                (mic),
        .allow_audio_writes (allow_audio_writes),
        .host_we            (host_we),
        .host_waddr         (host_waddr),
        .host_wdata         (host_wdata),
        .frame              (frame),
        .ram_we             (ram_we),
        .ram_waddr          (ram_waddr),
        .ram_wdata          (ram_wdata)
    );

    audio_ram u_ram (
        .ck    (ck),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    host_regs u_host (
        .ck                 (ck),
        .rst_n              (rst_n),
        .cyc                (cyc),
        .we                 (we),
        .adr                (adr),
        .dat                (dat),
        .ack                (ack),
        .rdt                (rdt),
        .frame              (frame),
        .allow_audio_writes (allow_audio_writes),
        .host_we            (host_we),
        .host_waddr         (host_waddr),
        .host_wdata         (host_wdata),
        .ram_raddr          (ram_raddr),
        .ram_rdata          (ram_rdata)
    );

endmodule

// ==== tests/audio_engine_chk.sv ====
`timescale 1ns/1ps

module audio_engine_chk (
    input logic ck,
    input logic rst_n,
    input logic cyc,
    input logic we,
    input logic ack,
    input logic frame_start,
    input logic allow_audio_writes,
    input logic ram_we
);

    // Ack is a one-cycle pulse
    ack_one_shot: assert property (@(posedge ck) disable iff (!rst_n) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    ack_in_cycle: assert property (@(posedge ck) disable iff (!rst_n) ack |-> cyc)
        else $error("ack without an active bus cycle");

    frame_pulse: assert property (@(posedge ck) disable iff (!rst_n)
        frame_start |=> !frame_start)
        else $error("frame_start longer than one cycle");

    // In host mode every RAM write must come from a bus write cycle
    no_capture_in_mode: assert property (@(posedge ck) disable iff (!rst_n)
        (allow_audio_writes && ram_we) |-> (cyc && we))
        else $error("capture write while host owns the audio RAM");

endmodule

bind audio_engine audio_engine_chk u_chk (.*);

// ==== tests/audio_engine_tb.sv ====
`timescale 1ns/1ps
`include "audio_params.svh"

module audio_engine_tb;

    import audio_pkg::*;

    localparam int NROWS = 6;
    localparam int NCH = `AUDIO_CHANNELS;
    // Table frames plus two frozen frames, one resumed frame and margin
    localparam int TIMEOUT_NS = (NROWS + 5) * 960 * 8;

    logic      ck;
    logic      rst_n;
    logic      cyc;
    logic      we;
    bus_word_t adr;
    bus_word_t dat;
    logic      ack;
    bus_word_t rdt;
    logic      sck;
    logic      ws;
    logic      sd_in0 = 1'b0;
    logic      sd_in1 = 1'b0;
    logic      sd_in2 = 1'b0;
    logic      sd_in3 = 1'b0;
    logic      frame_start;

    // Stimulus table, expected status after the frame_start that ends each row
    sample_t tbl_smp [NROWS][NCH];
    frame_t  tbl_frame [NROWS] = '{8'hFF, 8'hFE, 8'hFD, 8'hFC, 8'hFB, 8'hFA};

    logic    sck_prev;
    logic    ws_prev;
    int      half_pos;
    int      frame_no;
    sample_t host_val [NCH];

    audio_engine dut (.*);

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_frame(input string name, input frame_t exp, input frame_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    initial begin
        #TIMEOUT_NS;
        abort_run("timeout, the run did not complete in the expected number of frames");
    end

    // Samples sent in model frame k, frame 0 being the one right after reset
    function automatic sample_t sent_sample(input int k, input int ch);
        if (k >= 0 && k < NROWS) begin
            return tbl_smp[k][ch];
        end
        return {4'(ch), 4'h5, 8'(k)};
    endfunction

    task automatic drive_lines(input int k, input int t, input logic right);
        sample_t    s;
        logic [3:0] bits;
        for (int n = 0; n < 4; n++) begin
            s = sent_sample(k, 2 * n + right);
            bits[n] = (t >= 1 && t <= 16) ? s[16 - t] : 1'b0;
        end
        {sd_in3, sd_in2, sd_in1, sd_in0} = bits;
    endtask

    // I2S source, puts the bit for the next slot on the lines where sck falls
    always @(negedge ck) begin
        if (!rst_n) begin
            sck_prev = 1'b0;
            ws_prev  = 1'b1;
            half_pos = 0;
            frame_no = -1;
        end else begin
            if (sck_prev && !sck) begin
                if (ws != ws_prev) begin
                    half_pos = 0;
                    if (!ws) begin
                        frame_no++;
                    end
                end else begin
                    half_pos++;
                end
                ws_prev = ws;
                drive_lines(frame_no, half_pos + 1, ws);
            end
            sck_prev = sck;
        end
    end

    task automatic wait_frame();
        @(negedge ck);
        while (!frame_start) begin
            @(negedge ck);
        end
        // Capture writes the eight channels in the cycles after frame_start
        repeat (NCH) @(negedge ck);
    endtask

    task automatic bus_access(input logic wr, input bus_word_t a, input bus_word_t d,
                              output bus_word_t r);
        int waited;
        @(negedge ck);
        cyc = 1'b1;
        we  = wr;
        adr = a;
        dat = d;
        waited = 0;
        do begin
            @(negedge ck);
            waited++;
            if (waited > 8) begin
                abort_run("bus cycle was not acknowledged");
            end
        end while (!ack);
        r = rdt;
        // Cycle stays up until the edge that ends the ack
        @(negedge ck);
        cyc = 1'b0;
        we  = 1'b0;
    endtask

    function automatic bus_word_t status_adr(input int off);
        return {`ADDR_STATUS, 24'(off << 2)};
    endfunction

    function automatic bus_word_t input_adr(input int ch, input int fr);
        return {`ADDR_INPUT, 24'((ch * `AUDIO_FRAMES + fr) << 2)};
    endfunction

    initial begin
        bus_word_t rd;
        frame_t    frozen;
        void'($urandom(28));
        tbl_smp[0] = '{16'h8001, 16'h7FFE, 16'hA5A5, 16'h5A5A,
                       16'hFFFF, 16'h0000, 16'h1234, 16'hFEDC};
        for (int r = 1; r < NROWS; r++) begin
            for (int c = 0; c < NCH; c++) begin
                tbl_smp[r][c] = sample_t'($urandom);
            end
        end
        rst_n = 1'b0;
        cyc   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat   = '0;
        repeat (5) @(negedge ck);
        rst_n = 1'b1;

        bus_access(1'b0, status_adr(0), '0, rd);
        check_word("control after reset", 32'h0, rd);
        bus_access(1'b0, status_adr(1), '0, rd);
        check_frame("status after reset", 8'h00, frame_t'(rd[7:0]));

        // Unknown region must stay unanswered
        @(negedge ck);
        cyc = 1'b1;
        adr = 32'h7000_0000;
        repeat (4) begin
            @(negedge ck);
            if (ack) begin
                abort_run("access to an unknown region was acknowledged");
            end
        end
        cyc = 1'b0;

        for (int r = 0; r < NROWS; r++) begin
            wait_frame();
            bus_access(1'b0, status_adr(1), '0, rd);
            check_frame($sformatf("status row %0d", r), tbl_frame[r], frame_t'(rd[7:0]));
            for (int c = 0; c < NCH; c++) begin
                bus_access(1'b0, input_adr(c, tbl_frame[r]), '0, rd);
                check_sample($sformatf("row %0d channel %0d", r, c), tbl_smp[r][c],
                             sample_t'(rd[15:0]));
            end
        end

        // Host takes over the RAM, counter must hold
        bus_access(1'b1, status_adr(0), 32'h1, rd);
        bus_access(1'b0, status_adr(0), '0, rd);
        check_word("control set", 32'h1, rd);
        frozen = tbl_frame[NROWS-1];
        repeat (2) begin
            wait_frame();
            bus_access(1'b0, status_adr(1), '0, rd);
            check_frame("status frozen", frozen, frame_t'(rd[7:0]));
        end
        for (int c = 0; c < NCH; c++) begin
            host_val[c] = sample_t'($urandom);
            bus_access(1'b1, input_adr(c, 16 + c), {16'hDEAD, host_val[c]}, rd);
        end
        for (int c = 0; c < NCH; c++) begin
            bus_access(1'b0, input_adr(c, 16 + c), '0, rd);
            check_word($sformatf("host write channel %0d", c), {16'h0, host_val[c]}, rd);
        end
        for (int r = 0; r < NROWS; r++) begin
            for (int c = 0; c < NCH; c++) begin
                bus_access(1'b0, input_adr(c, tbl_frame[r]), '0, rd);
                check_sample($sformatf("kept row %0d channel %0d", r, c), tbl_smp[r][c],
                             sample_t'(rd[15:0]));
            end
        end

        // Back to capture, the frame after the two frozen ones gets stored
        bus_access(1'b1, status_adr(0), 32'h0, rd);
        wait_frame();
        bus_access(1'b0, status_adr(1), '0, rd);
        check_frame("status resumed", frame_t'(frozen - 1), frame_t'(rd[7:0]));
        for (int c = 0; c < NCH; c++) begin
            bus_access(1'b0, input_adr(c, frame_t'(frozen - 1)), '0, rd);
            check_sample($sformatf("resumed channel %0d", c), sent_sample(NROWS + 2, c),
                         sample_t'(rd[15:0]));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== audio_engine.f ====
+incdir+hw
hw/audio_pkg.sv
hw/i2s_clock.sv
hw/i2s_rx.sv
hw/audio_capture.sv
hw/audio_ram.sv
hw/host_regs.sv
hw/audio_engine.sv
tests/audio_engine_chk.sv
tests/audio_engine_tb.sv

// ==== Bender.yml ====
package:
  name: audio_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/audio_pkg.sv
      - hw/i2s_clock.sv
      - hw/i2s_rx.sv
      - hw/audio_capture.sv
      - hw/audio_ram.sv
      - hw/host_regs.sv
      - hw/audio_engine.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/audio_engine_chk.sv
      - tests/audio_engine_tb.sv
